// ==== hdl/gf_vme_cfg.svh ====
`ifndef GF_VME_CFG_SVH
`define GF_VME_CFG_SVH

// bus widths
`define GF_ADDR_W           16
`define GF_DATA_W           32

// page codes in addr[15:8]
`define GF_PAGE_CONFIG      8'h80
`define GF_PAGE_STATUS      8'h81
`define GF_PAGE_SPYCNT      8'h82

// spy windows in addr[15:11], spy number in addr[10:9]
`define GF_SPY_WIN_BASE     5'b10001
`define GF_SPY_DEPTH_W      9
`define GF_NUM_SPY          4

`define GF_FIRMWARE_VERSION 32'h10011102

// ----------------------------------------
// configuration page offsets
// ----------------------------------------
`define GF_CFG_LOCAL_ADD    8'd0
`define GF_CFG_CONTROL      8'd1
`define GF_CFG_DCM          8'd2
`define GF_CFG_CHI2CUT      8'd3
`define GF_CFG_PHIOFF01     8'd4
`define GF_CFG_PHIOFF23     8'd5
`define GF_CFG_SECTORS      8'd6
`define GF_CFG_CDF_MASK     8'd7
`define GF_CFG_SVT_MASK     8'd8

// ----------------------------------------
// status page offsets
// ----------------------------------------
`define GF_ST_FIRMWARE      8'd0
`define GF_ST_GF_STATUS     8'd1
`define GF_ST_LAST50H       8'd2
`define GF_ST_WEDGE0        8'd3
`define GF_ST_WEDGE1        8'd4
`define GF_ST_WEDGE2        8'd5
`define GF_ST_WEDGE3        8'd6
`define GF_ST_ERROR         8'd7

`endif

// ==== hdl/gf_vme_pkg.sv ====
`include "gf_vme_cfg.svh"

package gf_vme_pkg;

	typedef logic [`GF_ADDR_W-1:0] vme_addr_t;
	typedef logic [`GF_DATA_W-1:0] vme_data_t;

	// offset below the page code
	typedef logic [7:0] page_off_t;

	typedef logic [`GF_SPY_DEPTH_W-1:0] spy_idx_t;
	typedef logic [$clog2(`GF_NUM_SPY)-1:0] spy_sel_t;
	typedef logic [1:0] wedge_sel_t;

	typedef enum logic [1:0]
	{
		FRONT_IDLE,
		FRONT_WAIT,
		FRONT_RESP
	} front_state_t;

endpackage

// ==== hdl/vme_bus_if.sv ====
`timescale 1ns/1ps

// one register page hanging off the front end
interface vme_bus_if
	import gf_vme_pkg::*;
();
	logic      req;
	logic      write;
	vme_addr_t addr;
	vme_data_t wdata;
	logic      ack;
	vme_data_t rdata;

	modport master
	(
		output req, write, addr, wdata,
		input  ack, rdata
	);

	modport page
	(
		input  req, write, addr, wdata,
		output ack, rdata
	);
endinterface

// ==== hdl/vme_slave_front.sv ====
`timescale 1ns/1ps
`include "gf_vme_cfg.svh"

module vme_slave_front
	import gf_vme_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      mezzanine_sel,
	input  logic      cmd_valid,
	input  logic      cmd_write,
	input  logic      cmd_mezzanine,
	input  vme_addr_t cmd_addr,
	input  vme_data_t cmd_wdata,
	output logic      cmd_ready,
	output logic      rsp_valid,
	output vme_data_t rsp_rdata,
	input  logic      rsp_ready,
	vme_bus_if.master cfg_bus,
	vme_bus_if.master st_bus,
	vme_bus_if.master spy_bus
);
	logic         mezz_sel_q;
	logic         cmd_take;
	logic         cmd_match;
	logic [7:0]   page_code;
	logic         hit_cfg;
	logic         hit_st;
	logic         hit_spy;
	logic         no_page;
	logic         write_q;
	vme_addr_t    addr_q;
	vme_data_t    wdata_q;
	front_state_t state;

	// mezzanine selection sampled every cycle
	always_ff @(posedge clk)
	begin
		mezz_sel_q <= mezzanine_sel;
	end

	assign cmd_ready = (state == FRONT_IDLE);
	assign rsp_valid = (state == FRONT_RESP);
	assign cmd_take  = cmd_valid && cmd_ready;
	assign cmd_match = (cmd_mezzanine == mezz_sel_q);

	// ----------------------------------------
	// page routing
	// ----------------------------------------
	assign page_code = cmd_addr[`GF_ADDR_W-1 -: 8];
	assign hit_cfg   = (page_code == `GF_PAGE_CONFIG);
	assign hit_st    = (page_code == `GF_PAGE_STATUS);
	assign hit_spy   = (page_code == `GF_PAGE_SPYCNT) ||
		(cmd_addr[`GF_ADDR_W-1 -: 5] == `GF_SPY_WIN_BASE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state       <= FRONT_IDLE;
			cfg_bus.req <= 1'b0;
			st_bus.req  <= 1'b0;
			spy_bus.req <= 1'b0;
			no_page     <= 1'b0;
		end
		else
		begin
			cfg_bus.req <= 1'b0;
			st_bus.req  <= 1'b0;
			spy_bus.req <= 1'b0;
			no_page     <= 1'b0;
			case (state)
				FRONT_IDLE:
				begin
					// commands for other boards are swallowed here
					if (cmd_take && cmd_match)
					begin
						state       <= FRONT_WAIT;
						cfg_bus.req <= hit_cfg;
						st_bus.req  <= hit_st;
						spy_bus.req <= hit_spy;
						no_page     <= !(hit_cfg || hit_st || hit_spy);
					end
				end
				FRONT_WAIT:
				begin
					if (no_page || cfg_bus.ack || st_bus.ack || spy_bus.ack)
						state <= FRONT_RESP;
				end
				FRONT_RESP:
				begin
					if (rsp_ready)
						state <= FRONT_IDLE;
				end
				default:
					state <= FRONT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_take)
		begin
			write_q <= cmd_write;
			addr_q  <= cmd_addr;
			wdata_q <= cmd_wdata;
		end
		// data is frozen once the FSM reaches FRONT_RESP
		if (state == FRONT_WAIT)
		begin
			if (cfg_bus.ack)
				rsp_rdata <= cfg_bus.rdata;
			else if (st_bus.ack)
				rsp_rdata <= st_bus.rdata;
			else if (spy_bus.ack)
				rsp_rdata <= spy_bus.rdata;
			else
				rsp_rdata <= '0;
		end
	end

	assign cfg_bus.write = write_q;
	assign cfg_bus.addr  = addr_q;
	assign cfg_bus.wdata = wdata_q;
	assign st_bus.write  = write_q;
	assign st_bus.addr   = addr_q;
	assign st_bus.wdata  = wdata_q;
	assign spy_bus.write = write_q;
	assign spy_bus.addr  = addr_q;
	assign spy_bus.wdata = wdata_q;
endmodule

// ==== hdl/vme_config_regs.sv ====
`timescale 1ns/1ps
`include "gf_vme_cfg.svh"

module vme_config_regs
	import gf_vme_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	vme_bus_if.page   bus,
	output vme_data_t local_add,
	output vme_data_t control,
	output vme_data_t dcm,
	output vme_data_t chi2cut,
	output vme_data_t phioffset_w0w1,
	output vme_data_t phioffset_w2w3,
	output vme_data_t sectors,
	output vme_data_t cdf_error_mask,
	output vme_data_t svt_error_mask,
	output logic      dcm_write
);
	page_off_t off;

	assign off = bus.addr[7:0];

	// ----------------------------------------
	// register writes
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			local_add      <= '0;
			control        <= '0;
			dcm            <= '0;
			chi2cut        <= '0;
			phioffset_w0w1 <= '0;
			phioffset_w2w3 <= '0;
			sectors        <= '0;
			cdf_error_mask <= '0;
			svt_error_mask <= '0;
			dcm_write      <= 1'b0;
			bus.ack        <= 1'b0;
		end
		else
		begin
			bus.ack   <= bus.req;
			dcm_write <= 1'b0;
			if (bus.req && bus.write)
			begin
				case (off)
					`GF_CFG_LOCAL_ADD: local_add      <= bus.wdata;
					`GF_CFG_CONTROL:   control        <= bus.wdata;
					`GF_CFG_CHI2CUT:   chi2cut        <= bus.wdata;
					`GF_CFG_PHIOFF01:  phioffset_w0w1 <= bus.wdata;
					`GF_CFG_PHIOFF23:  phioffset_w2w3 <= bus.wdata;
					`GF_CFG_SECTORS:   sectors        <= bus.wdata;
					`GF_CFG_CDF_MASK:  cdf_error_mask <= bus.wdata;
					`GF_CFG_SVT_MASK:  svt_error_mask <= bus.wdata;
					`GF_CFG_DCM:
					begin
						// clock manager reloads on the strobe
						dcm       <= bus.wdata;
						dcm_write <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// read-back, zero for writes and holes
	always_ff @(posedge clk)
	begin
		bus.rdata <= '0;
		if (bus.req && !bus.write)
		begin
			case (off)
				`GF_CFG_LOCAL_ADD: bus.rdata <= local_add;
				`GF_CFG_CONTROL:   bus.rdata <= control;
				`GF_CFG_DCM:       bus.rdata <= dcm;
				`GF_CFG_CHI2CUT:   bus.rdata <= chi2cut;
				`GF_CFG_PHIOFF01:  bus.rdata <= phioffset_w0w1;
				`GF_CFG_PHIOFF23:  bus.rdata <= phioffset_w2w3;
				`GF_CFG_SECTORS:   bus.rdata <= sectors;
				`GF_CFG_CDF_MASK:  bus.rdata <= cdf_error_mask;
				`GF_CFG_SVT_MASK:  bus.rdata <= svt_error_mask;
				default:           bus.rdata <= '0;
			endcase
		end
	end
endmodule

// ==== hdl/vme_status_regs.sv ====
`timescale 1ns/1ps
`include "gf_vme_cfg.svh"

module vme_status_regs
	import gf_vme_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	vme_bus_if.page         bus,
	input  vme_data_t       gf_status,
	input  vme_data_t       last_50h,
	input  vme_data_t       error_reg,
	input  vme_data_t [3:0] wedge_status,
	output logic [3:0]      clear_wedge_status,
	output logic            clear_error
);
	page_off_t  off;
	logic       is_wedge;
	wedge_sel_t wsel;

	assign off      = bus.addr[7:0];
	assign is_wedge = (off >= `GF_ST_WEDGE0) && (off <= `GF_ST_WEDGE3);
	// wedge offsets are contiguous
	assign wsel     = wedge_sel_t'(off - `GF_ST_WEDGE0);

	// ----------------------------------------
	// write-to-clear strobes
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clear_wedge_status <= '0;
			clear_error        <= 1'b0;
			bus.ack            <= 1'b0;
		end
		else
		begin
			bus.ack            <= bus.req;
			clear_wedge_status <= '0;
			clear_error        <= 1'b0;
			if (bus.req && bus.write)
			begin
				if (is_wedge)
					clear_wedge_status <= 4'b0001 << wsel;
				clear_error <= (off == `GF_ST_ERROR);
			end
		end
	end

	// inputs are sampled when the read arrives
	always_ff @(posedge clk)
	begin
		bus.rdata <= '0;
		if (bus.req && !bus.write)
		begin
			if (is_wedge)
				bus.rdata <= wedge_status[wsel];
			else if (off == `GF_ST_FIRMWARE)
				bus.rdata <= `GF_FIRMWARE_VERSION;
			else if (off == `GF_ST_GF_STATUS)
				bus.rdata <= gf_status;
			else if (off == `GF_ST_LAST50H)
				bus.rdata <= last_50h;
			else if (off == `GF_ST_ERROR)
				bus.rdata <= error_reg;
		end
	end
endmodule

// ==== hdl/vme_spy_window.sv ====
`timescale 1ns/1ps
`include "gf_vme_cfg.svh"

module vme_spy_window
	import gf_vme_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	vme_bus_if.page                     bus,
	input  vme_data_t [`GF_NUM_SPY-1:0] spy_counter,
	input  vme_data_t                   spy_word,
	output logic                        spy_read,
	output spy_sel_t                    spy_sel,
	output spy_idx_t                    spy_addr,
	output logic [`GF_NUM_SPY-1:0]      spy_reset
);
	page_off_t off;
	spy_sel_t  cnt_sel;
	logic      in_window;
	logic      cnt_hit;
	logic      win_pend;

	assign off       = bus.addr[7:0];
	assign in_window = (bus.addr[`GF_ADDR_W-1 -: 5] == `GF_SPY_WIN_BASE);
	assign cnt_hit   = !in_window && (off < `GF_NUM_SPY);
	assign cnt_sel   = spy_sel_t'(off);

	// ----------------------------------------
	// window access to the spy memories
	// ----------------------------------------
	// spy number follows window order above the word index
	assign spy_sel  = bus.addr[`GF_SPY_DEPTH_W +: $bits(spy_sel_t)];
	assign spy_addr = bus.addr[`GF_SPY_DEPTH_W-1:0];
	assign spy_read = bus.req && in_window && !bus.write;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			win_pend  <= 1'b0;
			spy_reset <= '0;
			bus.ack   <= 1'b0;
		end
		else
		begin
			win_pend  <= spy_read;
			// window reads wait one more edge for the memory word
			bus.ack   <= (bus.req && !spy_read) || win_pend;
			spy_reset <= '0;
			if (bus.req && bus.write && cnt_hit)
				spy_reset <= `GF_NUM_SPY'(1) << cnt_sel;
		end
	end

	always_ff @(posedge clk)
	begin
		if (win_pend)
			bus.rdata <= spy_word;
		else if (bus.req && !bus.write && cnt_hit)
			bus.rdata <= spy_counter[cnt_sel];
		else
			bus.rdata <= '0;
	end
endmodule

// ==== hdl/gf_vme_interface.sv ====
`timescale 1ns/1ps
`include "gf_vme_cfg.svh"

module gf_vme_interface
	import gf_vme_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        mezzanine_sel,
	// host command and response channels
	input  logic                        cmd_valid,
	output logic                        cmd_ready,
	input  logic                        cmd_write,
	input  vme_addr_t                   cmd_addr,
	input  vme_data_t                   cmd_wdata,
	input  logic                        cmd_mezzanine,
	output logic                        rsp_valid,
	input  logic                        rsp_ready,
	output vme_data_t                   rsp_rdata,
	// board configuration
	output vme_data_t                   local_add,
	output vme_data_t                   control,
	output vme_data_t                   dcm,
	output logic                        dcm_write,
	output vme_data_t                   chi2cut,
	output vme_data_t                   phioffset_w0w1,
	output vme_data_t                   phioffset_w2w3,
	output vme_data_t                   sectors,
	output vme_data_t                   cdf_error_mask,
	output vme_data_t                   svt_error_mask,
	// board status
	input  vme_data_t                   gf_status,
	input  vme_data_t                   last_50h,
	input  vme_data_t [3:0]             wedge_status,
	output logic [3:0]                  clear_wedge_status,
	input  vme_data_t                   error_reg,
	output logic                        clear_error,
	// input spy buffers
	input  vme_data_t [`GF_NUM_SPY-1:0] spy_counter,
	input  vme_data_t                   spy_word,
	output logic                        spy_read,
	output spy_sel_t                    spy_sel,
	output spy_idx_t                    spy_addr,
	output logic [`GF_NUM_SPY-1:0]      spy_reset
);
	vme_bus_if cfg_bus ();
	vme_bus_if st_bus ();
	vme_bus_if spy_bus ();

	vme_slave_front vme_slave_front_inst
	(
		.clk           (clk),
		.rst           (rst),
		.mezzanine_sel (mezzanine_sel),
		.cmd_valid     (cmd_valid),
		.cmd_write     (cmd_write),
		.cmd_mezzanine (cmd_mezzanine),
		.cmd_addr      (cmd_addr),
		.cmd_wdata     (cmd_wdata),
		.cmd_ready     (cmd_ready),
		.rsp_valid     (rsp_valid),
		.rsp_rdata     (rsp_rdata),
		.rsp_ready     (rsp_ready),
		.cfg_bus       (cfg_bus.master),
		.st_bus        (st_bus.master),
		.spy_bus       (spy_bus.master)
	);

	vme_config_regs vme_config_regs_inst
	(
		.clk            (clk),
		.rst            (rst),
		.bus            (cfg_bus.page),
		.local_add      (local_add),
		.control        (control),
		.dcm            (dcm),
		.chi2cut        (chi2cut),
		.phioffset_w0w1 (phioffset_w0w1),
		.phioffset_w2w3 (phioffset_w2w3),
		.sectors        (sectors),
		.cdf_error_mask (cdf_error_mask),
		.svt_error_mask (svt_error_mask),
		.dcm_write      (dcm_write)
	);

	vme_status_regs vme_status_regs_inst
	(
		.clk                (clk),
		.rst                (rst),
		.bus                (st_bus.page),
		.gf_status          (gf_status),
		.last_50h           (last_50h),
		.error_reg          (error_reg),
		.wedge_status       (wedge_status),
		.clear_wedge_status (clear_wedge_status),
		.clear_error        (clear_error)
	);

	vme_spy_window vme_spy_window_inst
	(
		.clk         (clk),
		.rst         (rst),
		.bus         (spy_bus.page),
		.spy_counter (spy_counter),
		.spy_word    (spy_word),
		.spy_read    (spy_read),
		.spy_sel     (spy_sel),
		.spy_addr    (spy_addr),
		.spy_reset   (spy_reset)
	);
endmodule

// ==== verification/tb_gf_vme.sv ====
`timescale 1ns/1ps
`include "gf_vme_cfg.svh"

module tb_gf_vme;
	localparam int MAX_CMDS = 64;

	logic                                  clk = 1'b0;
	logic                                  rst;
	logic                                  mezzanine_sel;
	logic                                  cmd_valid;
	logic                                  cmd_ready;
	logic                                  cmd_write;
	logic [`GF_ADDR_W-1:0]                 cmd_addr;
	logic [`GF_DATA_W-1:0]                 cmd_wdata;
	logic                                  cmd_mezzanine;
	logic                                  rsp_valid;
	logic                                  rsp_ready = 1'b0;
	logic [`GF_DATA_W-1:0]                 rsp_rdata;
	logic [`GF_DATA_W-1:0]                 local_add;
	logic [`GF_DATA_W-1:0]                 control;
	logic [`GF_DATA_W-1:0]                 dcm;
	logic                                  dcm_write;
	logic [`GF_DATA_W-1:0]                 chi2cut;
	logic [`GF_DATA_W-1:0]                 phioffset_w0w1;
	logic [`GF_DATA_W-1:0]                 phioffset_w2w3;
	logic [`GF_DATA_W-1:0]                 sectors;
	logic [`GF_DATA_W-1:0]                 cdf_error_mask;
	logic [`GF_DATA_W-1:0]                 svt_error_mask;
	logic [`GF_DATA_W-1:0]                 gf_status;
	logic [`GF_DATA_W-1:0]                 last_50h;
	logic [3:0][`GF_DATA_W-1:0]            wedge_status;
	logic [3:0]                            clear_wedge_status;
	logic [`GF_DATA_W-1:0]                 error_reg;
	logic                                  clear_error;
	logic [`GF_NUM_SPY-1:0][`GF_DATA_W-1:0] spy_counter;
	logic [`GF_DATA_W-1:0]                 spy_word = '0;
	logic                                  spy_read;
	logic [1:0]                            spy_sel;
	logic [`GF_SPY_DEPTH_W-1:0]            spy_addr;
	logic [`GF_NUM_SPY-1:0]                spy_reset;

	// flag, op, address, write data, expected read data
	logic [87:0]           stim [MAX_CMDS];
	int                    cmd_total = 0;
	logic [15:0]           lfsr = 16'd27799;
	logic [`GF_DATA_W-1:0] rsp_queue [$];
	logic                  holding = 1'b0;
	logic [`GF_DATA_W-1:0] held_data;
	int                    dcm_count = 0;
	int                    dcm_expected = 0;
	int                    error_count = 0;
	int                    error_expected = 0;
	int                    wedge_count [4] = '{default: 0};
	int                    wedge_expected [4] = '{default: 0};
	int                    spy_reset_count [4] = '{default: 0};
	int                    spy_reset_expected [4] = '{default: 0};
	// last written value of each configuration word
	logic [`GF_DATA_W-1:0] cfg_shadow [9] = '{default: '0};

	gf_vme_interface gf_vme_interface_inst (.*);

	always #5 clk = ~clk;

	// spy memory model returns the word one cycle after the read
	always @(posedge clk)
	begin
		if (spy_read)
			spy_word <= 32'(spy_sel) * 32'h1000 + 32'(spy_addr);
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		// taps 16 14 13 11
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// random back-pressure on the response channel
	always @(posedge clk)
	begin
		#1;
		lfsr = lfsr_step(lfsr);
		rsp_ready = lfsr[0];
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp_val,
		input string what);
		if (got !== exp_val)
		begin
			$display("error at %0t ns: %s: got %h, expected %h", $time, what, got, exp_val);
			$display("Simulation FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// ----------------------------------------
	// response and strobe monitor
	// ----------------------------------------
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (holding)
			begin
				check_value(32'(rsp_valid), 32'd1, "response dropped before it was taken");
				check_value(rsp_rdata, held_data, "response data changed while held");
			end
			if (rsp_valid)
				check_value(32'(cmd_ready), 32'd0, "command ready while a response is pending");
			holding = 1'b0;
			if (rsp_valid && rsp_ready)
				rsp_queue.push_back(rsp_rdata);
			else if (rsp_valid)
			begin
				holding = 1'b1;
				held_data = rsp_rdata;
			end
			if (dcm_write)
				dcm_count++;
			if (clear_error)
				error_count++;
			for (int i = 0; i < 4; i++)
			begin
				if (clear_wedge_status[i])
					wedge_count[i]++;
				if (spy_reset[i])
					spy_reset_count[i]++;
			end
		end
	end

	function automatic logic [31:0] config_port(input logic [7:0] off);
		case (off)
			`GF_CFG_LOCAL_ADD: return local_add;
			`GF_CFG_CONTROL:   return control;
			`GF_CFG_DCM:       return dcm;
			`GF_CFG_CHI2CUT:   return chi2cut;
			`GF_CFG_PHIOFF01:  return phioffset_w0w1;
			`GF_CFG_PHIOFF23:  return phioffset_w2w3;
			`GF_CFG_SECTORS:   return sectors;
			`GF_CFG_CDF_MASK:  return cdf_error_mask;
			`GF_CFG_SVT_MASK:  return svt_error_mask;
			default:           return '0;
		endcase
	endfunction

	task automatic load_commands;
		$readmemh("verification/vme_input.txt", stim);
		while (cmd_total < MAX_CMDS && stim[cmd_total][87:84] != 4'hF)
			cmd_total++;
		if (cmd_total == MAX_CMDS)
		begin
			$display("Simulation FAILED");
			$fatal(1, "the stimulus file has no end marker");
		end
	endtask

	task automatic send_command(input logic match, input logic wr,
		input logic [15:0] addr, input logic [31:0] wdata);
		@(posedge clk);
		#1;
		cmd_valid     = 1'b1;
		cmd_write     = wr;
		cmd_addr      = addr;
		cmd_wdata     = wdata;
		cmd_mezzanine = match ? mezzanine_sel : ~mezzanine_sel;
		@(negedge clk);
		while (!cmd_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	// expected side effects of an accepted write
	task automatic note_write(input logic [15:0] addr, input logic [31:0] wdata);
		logic [7:0] page;
		logic [7:0] off;
		logic [7:0] rel;
		page = addr[15:8];
		off  = addr[7:0];
		rel  = off - `GF_ST_WEDGE0;
		if (page == `GF_PAGE_CONFIG)
		begin
			check_value(config_port(off), wdata, "configuration output port");
			if (off <= `GF_CFG_SVT_MASK)
				cfg_shadow[off[3:0]] = wdata;
			if (off == `GF_CFG_DCM)
				dcm_expected++;
		end
		else if (page == `GF_PAGE_STATUS)
		begin
			if (off >= `GF_ST_WEDGE0 && off <= `GF_ST_WEDGE3)
				wedge_expected[rel[1:0]]++;
			else if (off == `GF_ST_ERROR)
				error_expected++;
		end
		else if (page == `GF_PAGE_SPYCNT && off < `GF_NUM_SPY)
			spy_reset_expected[off[1:0]]++;
	endtask

	task automatic run_command(input logic [87:0] cmd);
		logic        match;
		logic        wr;
		logic [15:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp_data;
		logic [31:0] got;
		match    = cmd[84];
		wr       = cmd[80];
		addr     = cmd[79:64];
		wdata    = cmd[63:32];
		exp_data = cmd[31:0];
		check_value(32'(rsp_queue.size()), 32'd0, "response without a command");
		send_command(match, wr, addr, wdata);
		if (!match)
		begin
			// another board's command must stay silent
			repeat (20)
			begin
				@(negedge clk);
				check_value(32'(rsp_valid), 32'd0, "response to another board's command");
			end
			check_value(32'(rsp_queue.size()), 32'd0, "responses queued after foreign command");
		end
		else
		begin
			while (rsp_queue.size() == 0)
				@(negedge clk);
			check_value(32'(rsp_queue.size()), 32'd1, "responses per command");
			got = rsp_queue.pop_front();
			check_value(got, exp_data, $sformatf("response data for address %h", addr));
			if (wr)
				note_write(addr, wdata);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		rst           = 1'b1;
		mezzanine_sel = 1'b1;
		cmd_valid     = 1'b0;
		cmd_write     = 1'b0;
		cmd_addr      = '0;
		cmd_wdata     = '0;
		cmd_mezzanine = 1'b0;
		gf_status     = 32'h5A5A0F0F;
		last_50h      = 32'h50C0FFEE;
		error_reg     = 32'hE0000003;
		for (int i = 0; i < 4; i++)
		begin
			wedge_status[i] = 32'hA0000000 + 32'(i);
			spy_counter[i]  = 32'h5C000000 + 32'(i);
		end
		load_commands();
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < cmd_total; i++)
			run_command(stim[i]);
		repeat (4) @(posedge clk);
		check_value(32'(rsp_queue.size()), 32'd0, "response after the last command");
		check_value(32'(dcm_count), 32'(dcm_expected), "dcm_write pulses");
		check_value(32'(error_count), 32'(error_expected), "clear_error pulses");
		for (int i = 0; i < 4; i++)
		begin
			check_value(32'(wedge_count[i]), 32'(wedge_expected[i]), "clear_wedge_status pulses");
			check_value(32'(spy_reset_count[i]), 32'(spy_reset_expected[i]), "spy_reset pulses");
		end
		// untouched words keep their reset value
		for (int i = 0; i < 9; i++)
			check_value(config_port(8'(i)), cfg_shadow[i], $sformatf("configuration word %0d", i));
		$display("Simulation PASSED");
		$finish;
	end

	// watchdog scaled to the number of commands
	initial
	begin
		wait (cmd_total != 0);
		repeat (16 + 200 * cmd_total) @(posedge clk);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired before all commands completed");
	end
endmodule

// ==== verification/vme_input.txt ====
// columns: match(1)/foreign(0) _ write(1)/read(0) _ address _ write data _ expected read data
// a line with F in the first column ends the list
1_1_8000_00000042_00000000 // local address
1_0_8000_00000000_00000042
1_1_8002_12345678_00000000 // dcm, strobes dcm_write
1_0_8002_00000000_12345678
1_1_8008_0000F00D_00000000 // svt error mask
1_0_8008_00000000_0000F00D
1_0_8100_00000000_10011102 // firmware version
1_0_8101_00000000_5A5A0F0F
1_0_8102_00000000_50C0FFEE
1_0_8105_00000000_A0000002 // wedge 2
1_0_8107_00000000_E0000003
1_1_8104_00000001_00000000 // clear wedge 1
1_1_8107_00000001_00000000 // clear error
1_0_8DA3_00000000_000021A3 // spy 2 word 1a3
1_0_8B00_00000000_00001100 // spy 1 word 100
1_0_8203_00000000_5C000003 // spy counter 3
1_1_8202_00000000_00000000 // reset spy counter 2
0_1_8000_DEADBEEF_00000000 // foreign board, ignored
1_0_8000_00000000_00000042
1_0_9000_00000000_00000000 // unmapped page
F_0_0000_00000000_00000000

// ==== flist.f ====
+incdir+hdl
hdl/gf_vme_pkg.sv
hdl/vme_bus_if.sv
hdl/vme_slave_front.sv
hdl/vme_config_regs.sv
hdl/vme_status_regs.sv
hdl/vme_spy_window.sv
hdl/gf_vme_interface.sv
verification/tb_gf_vme.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
TOP       := tb_gf_vme
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
